// File: src/dmac_defs.svh
/*
 * DMA destination stream side, shared width and depth definitions
 * Widths of the IDs, data path and burst length, and the queue depths
 */

`ifndef DMAC_DEFS_SVH
`define DMAC_DEFS_SVH

// **************************************************
// Burst tracking IDs
// **************************************************

// IDs wrap modulo 2**DMAC_ID_WIDTH, so eight bursts can be told apart
`define DMAC_ID_WIDTH 3

// **************************************************
// Data path
// **************************************************

// Width of both the upstream FIFO word and the stream beat
`define DMAC_DATA_WIDTH 64

// Burst length is stored as beats minus one, so 4 bits give 1 to 16 beats
`define DMAC_BEATS_WIDTH 4

// **************************************************
// Queues and response codes
// **************************************************

// Pending burst requests ahead of the data mover
`define DMAC_REQ_DEPTH 4

// Finished bursts waiting for their response to be taken
`define DMAC_RESP_DEPTH 4

// AXI OKAY response code, the only code this block ever reports
`define DMAC_RESP_OKAY 2'b00

`endif

// File: src/dmac_pkg.sv
/*
 * DMA destination stream side, shared types
 * Request, completion and response words plus the stage FSM encodings
 */

`include "dmac_defs.svh"

package dmac_pkg;

  // **************************************************
  // Words passed between the stages
  // **************************************************

  // One burst request as it enters the request queue
  typedef struct packed {
    // Number of beats in the burst, less one
    logic [`DMAC_BEATS_WIDTH-1:0] last_burst_length;
    // Set when this burst closes the whole transfer
    logic                         xlast;
  } burst_req_t;

  // Completion record from the data mover for each finished burst
  typedef struct packed {
    // Copy of the burst's xlast flag
    logic eot;
  } burst_done_t;

  // Response word presented at the top level
  typedef struct packed {
    // End of transfer, taken from the completed burst
    logic       eot;
    // AXI response code, OKAY in every case here
    logic [1:0] resp;
  } dmac_resp_t;

  // **************************************************
  // FSM encodings
  // **************************************************

  // Data mover: IDLE waits for a request, WAIT_ID holds it until the
  // source side has the data ready, STREAM moves the beats
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ID,
    STREAM
  } mover_state_e;

  // Response generator: whether a response is being offered
  typedef enum logic {
    RESP_IDLE,
    RESP_VALID
  } resp_state_e;

endpackage

// File: src/dmac_request_queue.sv
/*
 * Burst request queue, first stage of the destination side
 * Small circular FIFO of burst requests that is flushed while disabled
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module dmac_request_queue
  import dmac_pkg::*;
(
  input  logic       s_axis_aclk,
  input  logic       rst_n,
  input  logic       enable,
  input  logic       req_valid,
  output logic       req_ready,
  input  burst_req_t req,
  output logic       q_valid,
  output burst_req_t q_req,
  input  logic       q_pop
);

  localparam int DEPTH = `DMAC_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Request storage, written at wr_ptr and read at rd_ptr
  burst_req_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointer advance with wrap, so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // New requests are refused while the controller is being disabled
  assign req_ready = enable && (count != CNT_W'(DEPTH));
  assign push      = req_valid && req_ready;

  // The mover only pops while the head entry is valid
  assign pop     = q_pop && q_valid;
  assign q_valid = (count != '0);
  assign q_req   = mem[rd_ptr];

  // **************************************************
  // Pointers and fill count
  // **************************************************

  always_ff @(posedge s_axis_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (!enable) begin
      // Flush: anything still queued is dropped
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Count only moves when exactly one side is active
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage write, the entry becomes visible at q_valid one edge later
  always_ff @(posedge s_axis_aclk) begin
    if (push) begin
      mem[wr_ptr] <= req;
    end
  end

endmodule

// File: src/dmac_data_mover.sv
/*
 * Data mover, second stage of the destination side
 * Gates each burst on its ID, then passes FIFO beats to the stream port
 * and reports every finished burst to the response stage
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module dmac_data_mover
  import dmac_pkg::*;
(
  input  logic                        s_axis_aclk,
  input  logic                        rst_n,
  input  logic                        enable,

  // Request queue side
  input  logic                        q_valid,
  input  burst_req_t                  q_req,
  output logic                        q_pop,

  // Burst tracking
  input  logic [`DMAC_ID_WIDTH-1:0]   request_id,
  output logic [`DMAC_ID_WIDTH-1:0]   data_id,
  output logic                        mover_idle,

  // Upstream data FIFO
  input  logic                        fifo_valid,
  output logic                        fifo_ready,
  input  logic [`DMAC_DATA_WIDTH-1:0] fifo_data,

  // AXI-Stream master
  output logic                        m_axis_valid,
  input  logic                        m_axis_ready,
  output logic [`DMAC_DATA_WIDTH-1:0] m_axis_data,
  output logic                        m_axis_last,

  // Completion towards the response generator
  output logic                        done_valid,
  output burst_done_t                 done
);

  mover_state_e                 state;
  // Beats still to go in the current burst, zero on the final beat
  logic [`DMAC_BEATS_WIDTH-1:0] beats_left;
  // xlast of the loaded burst, held for the whole burst
  logic                         xlast_d;
  logic                         streaming;
  logic                         final_beat;
  logic                         beat_accept;

  // **************************************************
  // Handshakes
  // **************************************************

  // Take the next request as soon as one is waiting, unless disabled
  assign q_pop      = (state == IDLE) && q_valid && enable;
  assign mover_idle = (state == IDLE);
  assign streaming  = (state == STREAM);

  // In STREAM the FIFO and the stream port are joined without a register,
  // so back-pressure on m_axis_ready stalls the FIFO in the same cycle
  assign m_axis_valid = streaming && fifo_valid;
  assign fifo_ready   = streaming && m_axis_ready;
  assign m_axis_data  = fifo_data;
  assign beat_accept  = m_axis_valid && m_axis_ready;

  // last is only raised on the final beat of a burst that ends the transfer
  assign final_beat  = (beats_left == '0);
  assign m_axis_last = streaming && final_beat && xlast_d;

  // **************************************************
  // Burst FSM
  // **************************************************

  always_ff @(posedge s_axis_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      data_id    <= '0;
      done_valid <= 1'b0;
    end else begin
      // Completion is a single cycle pulse
      done_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (q_pop) begin
            state <= WAIT_ID;
          end
        end
        WAIT_ID: begin
          // A burst that has not started yet is dropped on disable
          if (!enable) begin
            state <= IDLE;
          end else if (data_id != request_id) begin
            // Source side has made this burst's data available
            state <= STREAM;
          end
        end
        STREAM: begin
          if (beat_accept && final_beat) begin
            state      <= IDLE;
            data_id    <= data_id + 1'b1;
            done_valid <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Burst length, xlast and completion payload
  always_ff @(posedge s_axis_aclk) begin
    if (q_pop) begin
      beats_left <= q_req.last_burst_length;
      xlast_d    <= q_req.xlast;
    end else if (beat_accept) begin
      beats_left <= beats_left - 1'b1;
    end
    if (beat_accept && final_beat) begin
      done <= '{eot: xlast_d};
    end
  end

endmodule

// File: src/dmac_response_generator.sv
/*
 * Response generator, third stage of the destination side
 * Queues burst completions and returns one OKAY response per burst
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module dmac_response_generator
  import dmac_pkg::*;
(
  input  logic                      s_axis_aclk,
  input  logic                      rst_n,
  input  logic                      done_valid,
  input  burst_done_t               done,
  output logic                      response_valid,
  input  logic                      response_ready,
  output dmac_resp_t                response,
  output logic [`DMAC_ID_WIDTH-1:0] response_id,
  output logic                      resp_busy
);

  localparam int DEPTH = `DMAC_RESP_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  burst_done_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  resp_state_e      state;
  // eot of the response currently offered
  logic             eot_q;
  logic             q_empty;
  logic             slot_free;
  logic             bypass;
  logic             push;
  logic             pop;
  logic             load;

  assign q_empty = (count == '0);

  // The response register can take a new entry when it is empty
  // or its current response is accepted at this edge
  assign slot_free = (state == RESP_IDLE) || response_ready;

  // Queued completions go first, a fresh one skips an empty queue
  // so the response follows done_valid by one cycle
  assign pop    = slot_free && !q_empty;
  assign bypass = slot_free && q_empty && done_valid;
  assign push   = done_valid && !bypass;
  assign load   = pop || bypass;

  assign response_valid = (state == RESP_VALID);
  assign response       = '{eot: eot_q, resp: `DMAC_RESP_OKAY};
  assign resp_busy      = (state == RESP_VALID) || !q_empty;

  // **************************************************
  // Response FSM and completion queue control
  // **************************************************

  always_ff @(posedge s_axis_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RESP_IDLE;
      response_id <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
    end else begin
      if (response_valid && response_ready) begin
        response_id <= response_id + 1'b1;
      end
      if (load) begin
        state <= RESP_VALID;
      end else if (slot_free) begin
        state <= RESP_IDLE;
      end
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // Completion storage and the offered response payload
  always_ff @(posedge s_axis_aclk) begin
    if (push) begin
      mem[wr_ptr] <= done;
    end
    if (load) begin
      eot_q <= pop ? mem[rd_ptr].eot : done.eot;
    end
  end

endmodule

// File: src/dmac_dest_axi_stream.sv
/*
 * DMA controller destination side with an AXI-Stream master port
 * Chains request queue, data mover and response generator
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module dmac_dest_axi_stream
  import dmac_pkg::*;
(
  input  logic                        s_axis_aclk,
  input  logic                        rst_n,

  input  logic                        enable,
  output logic                        enabled,

  input  logic [`DMAC_ID_WIDTH-1:0]   request_id,
  output logic [`DMAC_ID_WIDTH-1:0]   data_id,
  output logic [`DMAC_ID_WIDTH-1:0]   response_id,

  input  logic                        req_valid,
  output logic                        req_ready,
  input  burst_req_t                  req,

  input  logic                        fifo_valid,
  output logic                        fifo_ready,
  input  logic [`DMAC_DATA_WIDTH-1:0] fifo_data,

  output logic                        m_axis_valid,
  input  logic                        m_axis_ready,
  output logic [`DMAC_DATA_WIDTH-1:0] m_axis_data,
  output logic                        m_axis_last,

  output logic                        response_valid,
  input  logic                        response_ready,
  output dmac_resp_t                  response
);

  logic        q_valid;
  burst_req_t  q_req;
  logic        q_pop;
  logic        mover_idle;
  logic        mover_fifo_ready;
  logic        done_valid;
  burst_done_t done;
  logic        resp_busy;

  // **************************************************
  // Enable handshake
  // **************************************************

  // enabled follows enable up at once, but only drops after the last
  // streamed burst has been answered
  always_ff @(posedge s_axis_aclk or negedge rst_n) begin
    if (!rst_n) begin
      enabled <= 1'b0;
    end else if (enable) begin
      enabled <= 1'b1;
    end else if (mover_idle && !resp_busy) begin
      enabled <= 1'b0;
    end
  end

  // Drain the upstream FIFO while disabled so it cannot lock up
  assign fifo_ready = mover_fifo_ready | ~enabled;

  // **************************************************
  // Stages
  // **************************************************

  dmac_request_queue i_request_queue (
    .s_axis_aclk (s_axis_aclk),
    .rst_n       (rst_n),
    .enable      (enable),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .q_valid     (q_valid),
    .q_req       (q_req),
    .q_pop       (q_pop)
  );

  dmac_data_mover i_data_mover (
    .s_axis_aclk  (s_axis_aclk),
    .rst_n        (rst_n),
    .enable       (enable),
    .q_valid      (q_valid),
    .q_req        (q_req),
    .q_pop        (q_pop),
    .request_id   (request_id),
    .data_id      (data_id),
    .mover_idle   (mover_idle),
    .fifo_valid   (fifo_valid),
    .fifo_ready   (mover_fifo_ready),
    .fifo_data    (fifo_data),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis_data  (m_axis_data),
    .m_axis_last  (m_axis_last),
    .done_valid   (done_valid),
    .done         (done)
  );

  dmac_response_generator i_response_generator (
    .s_axis_aclk    (s_axis_aclk),
    .rst_n          (rst_n),
    .done_valid     (done_valid),
    .done           (done),
    .response_valid (response_valid),
    .response_ready (response_ready),
    .response       (response),
    .response_id    (response_id),
    .resp_busy      (resp_busy)
  );

endmodule

// File: test/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 8 ns clock with reset held low for the first 16 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic s_axis_aclk,
  output logic rst_n
);

  // Free running clock, 4 ns high and 4 ns low
  initial begin
    s_axis_aclk = 1'b0;
    forever #4 s_axis_aclk = ~s_axis_aclk;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(negedge s_axis_aclk);
    rst_n = 1'b1;
  end

endmodule

// File: test/dmac_dest_chk.sv
/*
 * Protocol checker for the DMA destination stream side
 * Stream hold rules, response hold rules and the fixed OKAY code
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module dmac_dest_chk
  import dmac_pkg::*;
(
  input logic                        s_axis_aclk,
  input logic                        rst_n,
  input logic                        m_axis_valid,
  input logic                        m_axis_ready,
  input logic [`DMAC_DATA_WIDTH-1:0] m_axis_data,
  input logic                        m_axis_last,
  input logic                        response_valid,
  input logic                        response_ready,
  input dmac_resp_t                  response
);

  // **************************************************
  // AXI-Stream master
  // **************************************************

  // A stalled beat keeps valid, data and last until the sink takes it
  property stream_hold_p;
    @(posedge s_axis_aclk) disable iff (!rst_n)
      (m_axis_valid && !m_axis_ready) |=>
        (m_axis_valid && $stable(m_axis_data) && $stable(m_axis_last));
  endproperty

  stream_hold_a: assert property (stream_hold_p)
    else $error("m_axis beat changed or was withdrawn while stalled");

  // **************************************************
  // Response port
  // **************************************************

  // An offered response stays up and unchanged until it is accepted
  property resp_hold_p;
    @(posedge s_axis_aclk) disable iff (!rst_n)
      (response_valid && !response_ready) |=>
        (response_valid && $stable(response));
  endproperty

  resp_hold_a: assert property (resp_hold_p)
    else $error("response changed or was withdrawn before it was accepted");

  // Error responses are not part of this block
  property resp_okay_p;
    @(posedge s_axis_aclk) disable iff (!rst_n)
      response_valid |-> (response.resp == `DMAC_RESP_OKAY);
  endproperty

  resp_okay_a: assert property (resp_okay_p)
    else $error("response carries a nonzero resp code");

endmodule

// Attach the checker to every instance of the top level
bind dmac_dest_axi_stream dmac_dest_chk chk (
  .s_axis_aclk    (s_axis_aclk),
  .rst_n          (rst_n),
  .m_axis_valid   (m_axis_valid),
  .m_axis_ready   (m_axis_ready),
  .m_axis_data    (m_axis_data),
  .m_axis_last    (m_axis_last),
  .response_valid (response_valid),
  .response_ready (response_ready),
  .response       (response)
);

// File: test/tb_dmac_dest.sv
/*
 * Testbench for the DMA destination stream side
 * Random bursts through ID gating, back-pressure and a disable cycle
 */

`timescale 1ns/1ps

`include "dmac_defs.svh"

module tb_dmac_dest
  import dmac_pkg::*;
();

  localparam int NUM_BURSTS = 13;
  localparam int ID_MOD     = 1 << `DMAC_ID_WIDTH;
  localparam logic [`DMAC_DATA_WIDTH-1:0] DATA_BASE = 64'h0bad_c0de_0000_0000;

  // Expected view of one stream beat
  typedef struct packed {
    logic [`DMAC_DATA_WIDTH-1:0] data;
    logic                        last;
    logic                        final_beat;
    int                          burst;
  } beat_exp_t;

  logic s_axis_aclk;
  logic rst_n;
  logic enable;
  logic enabled;
  logic [`DMAC_ID_WIDTH-1:0] request_id;
  logic [`DMAC_ID_WIDTH-1:0] data_id;
  logic [`DMAC_ID_WIDTH-1:0] response_id;
  logic req_valid;
  logic req_ready;
  burst_req_t req;
  logic fifo_valid;
  logic fifo_ready;
  logic [`DMAC_DATA_WIDTH-1:0] fifo_data;
  logic m_axis_valid;
  logic m_axis_ready;
  logic [`DMAC_DATA_WIDTH-1:0] m_axis_data;
  logic m_axis_last;
  logic response_valid;
  logic response_ready;
  dmac_resp_t response;

  // Burst list, lengths stored as beats minus one
  int   burst_len [NUM_BURSTS];
  logic burst_xlast [NUM_BURSTS];
  int   total_beats;
  int   cycle_limit;
  int   cycle_count;
  integer seed;

  // Progress seen at the DUT ports
  int beats_seen;
  int bursts_streamed;
  int resps_seen;
  int released;
  int release_limit;
  int fifo_count;
  int words_drained;
  logic release_on;
  logic drain_phase;
  logic beat_fired;
  logic fifo_fired;
  beat_exp_t exp_beat;
  int value_errors;
  int other_errors;

  tb_clock_gen clock_gen (
    .s_axis_aclk (s_axis_aclk),
    .rst_n       (rst_n)
  );

  dmac_dest_axi_stream dut (.*);

  // **************************************************
  // Reference model and checks
  // **************************************************

  // Global beat g carries FIFO word g, its burst comes from walking the list
  function automatic beat_exp_t expected_beat(input int g);
    beat_exp_t e;
    int start;
    e = '0;
    start = 0;
    e.data = DATA_BASE + `DMAC_DATA_WIDTH'(g);
    for (int b = 0; b < NUM_BURSTS; b++) begin
      if (g >= start && g <= start + burst_len[b]) begin
        e.burst      = b;
        e.final_beat = (g == start + burst_len[b]);
        e.last       = e.final_beat && burst_xlast[b];
      end
      start = start + burst_len[b] + 1;
    end
    return e;
  endfunction

  // Response r answers burst r and copies its xlast
  function automatic logic expected_eot(input int r);
    return burst_xlast[r];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      value_errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    other_errors++;
  endtask

  // Samples on the rising edge, where every DUT input has been stable for half a cycle
  always @(posedge s_axis_aclk) begin
    beat_fired = 1'b0;
    fifo_fired = 1'b0;
    if (rst_n) begin
      check_value("data_id", data_id, bursts_streamed % ID_MOD);
      check_value("response_id", response_id, resps_seen % ID_MOD);
      if (drain_phase) begin
        check_value("fifo_ready", fifo_ready, 1);
        check_value("req_ready", req_ready, 0);
      end
      if (m_axis_valid && m_axis_ready) begin
        beat_fired = 1'b1;
        if (beats_seen >= total_beats) begin
          report_problem("stream beat accepted after the last burst was complete");
        end else begin
          exp_beat = expected_beat(beats_seen);
          if (exp_beat.burst >= released) begin
            report_problem("stream beat accepted while request_id equalled data_id");
          end
          // Words drained while disabled move the FIFO ahead of the beat count
          check_value("m_axis_data", m_axis_data,
                      exp_beat.data + `DMAC_DATA_WIDTH'(words_drained));
          check_value("m_axis_last", m_axis_last, exp_beat.last);
          beats_seen++;
          if (exp_beat.final_beat) begin
            bursts_streamed++;
          end
        end
      end
      if (response_valid && response_ready) begin
        if (resps_seen >= bursts_streamed) begin
          report_problem("response issued with no finished burst left to answer");
        end else begin
          check_value("response.eot", response.eot, expected_eot(resps_seen));
          check_value("response.resp", response.resp, 0);
        end
        resps_seen++;
      end
      fifo_fired = fifo_valid && fifo_ready;
      // A word popped while disabled is thrown away and never streamed
      if (fifo_fired && !enabled) begin
        words_drained++;
      end
    end
  end

  // **************************************************
  // Random port activity on the falling edge
  // **************************************************

  always @(negedge s_axis_aclk) begin
    if (rst_n) begin
      m_axis_ready   = ($random(seed) & 3) != 0;
      response_ready = ($random(seed) & 1) != 0;
      // The FIFO keeps its head word offered until it is taken
      if (fifo_fired) begin
        fifo_count++;
      end
      if (fifo_fired || !fifo_valid) begin
        fifo_valid = ($random(seed) & 3) != 0;
      end
      fifo_data = DATA_BASE + `DMAC_DATA_WIDTH'(fifo_count);
      // Source side makes burst data available, at most three bursts ahead
      if (release_on && released < release_limit &&
          released - bursts_streamed < 3 && ($random(seed) & 1) != 0) begin
        released++;
        request_id = `DMAC_ID_WIDTH'(released);
      end
    end
  end

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_request(input int b);
    req_valid = 1'b1;
    req       = '{last_burst_length: `DMAC_BEATS_WIDTH'(burst_len[b]),
                  xlast: burst_xlast[b]};
    do begin
      @(posedge s_axis_aclk);
    end while (!req_ready);
    @(negedge s_axis_aclk);
    req_valid = 1'b0;
  endtask

  // Run limit scales with the amount of data in the burst list
  initial begin : watchdog
    cycle_count = 0;
    @(posedge rst_n);
    while (cycle_count < cycle_limit) begin
      @(posedge s_axis_aclk);
      cycle_count++;
    end
    $display("Timeout: run still busy after %0d cycles", cycle_count);
    $display("Summary: %0d beats, %0d responses, %0d value errors, %0d other errors",
             beats_seen, resps_seen, value_errors, other_errors + 1);
    $display("Test failures found");
    $finish;
  end

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    seed = 32'he1a2;
    enable = 1'b0;
    request_id = '0;
    req_valid = 1'b0;
    req = '0;
    fifo_valid = 1'b0;
    fifo_data = DATA_BASE;
    m_axis_ready = 1'b0;
    response_ready = 1'b0;
    beats_seen = 0;
    bursts_streamed = 0;
    resps_seen = 0;
    released = 0;
    release_limit = NUM_BURSTS - 1;
    fifo_count = 0;
    words_drained = 0;
    release_on = 1'b0;
    drain_phase = 1'b0;
    beat_fired = 1'b0;
    fifo_fired = 1'b0;
    value_errors = 0;
    other_errors = 0;
    total_beats = 0;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      burst_len[b]   = $random(seed) & 15;
      burst_xlast[b] = ($random(seed) & 1) != 0;
    end
    // Cover the longest burst and a closing burst with last
    burst_len[0] = 15;
    burst_xlast[NUM_BURSTS - 1] = 1'b1;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      total_beats = total_beats + burst_len[b] + 1;
    end
    cycle_limit = 40 * total_beats + 2000;

    @(posedge rst_n);
    @(negedge s_axis_aclk);
    check_value("enabled", enabled, 0);
    check_value("req_ready", req_ready, 0);
    check_value("m_axis_valid", m_axis_valid, 0);
    check_value("response_valid", response_valid, 0);
    enable = 1'b1;
    repeat (2) @(negedge s_axis_aclk);
    check_value("enabled", enabled, 1);

    // Requests queue up while request_id is held at data_id, then data is released
    fork
      begin
        for (int b = 0; b < NUM_BURSTS - 1; b++) begin
          send_request(b);
        end
      end
      begin
        repeat (60) @(negedge s_axis_aclk);
        release_on = 1'b1;
      end
    join
    while (resps_seen < NUM_BURSTS - 1) begin
      @(negedge s_axis_aclk);
    end

    // Disable with nothing in flight, the FIFO must drain and requests stay out
    enable    = 1'b0;
    req_valid = 1'b1;
    req       = '{last_burst_length: 4'd3, xlast: 1'b1};
    while (enabled) begin
      @(negedge s_axis_aclk);
    end
    drain_phase = 1'b1;
    repeat (30) @(negedge s_axis_aclk);
    drain_phase = 1'b0;
    req_valid   = 1'b0;

    // One more burst after enabling again
    enable = 1'b1;
    release_limit = NUM_BURSTS;
    send_request(NUM_BURSTS - 1);
    while (resps_seen < NUM_BURSTS) begin
      @(negedge s_axis_aclk);
    end
    repeat (5) @(negedge s_axis_aclk);
    check_value("beat count", beats_seen, total_beats);
    check_value("response count", resps_seen, NUM_BURSTS);

    $display("Summary: %0d beats, %0d responses, %0d value errors, %0d other errors",
             beats_seen, resps_seen, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/dmac_pkg.sv
src/dmac_request_queue.sv
src/dmac_data_mover.sv
src/dmac_response_generator.sv
src/dmac_dest_axi_stream.sv
test/tb_clock_gen.sv
test/dmac_dest_chk.sv
test/tb_dmac_dest.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the DMA destination testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_dmac_dest -o tb_dmac_dest > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_dmac_dest > sim.log 2>&1
cat sim.log

# The run counts as passed only if the testbench printed its pass line
grep -q "All tests passed!" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
